//--- all.f
+incdir+include
rtl/pyramid_pkg.sv
rtl/level_buffer.sv
rtl/blur_engine.sv
rtl/downsample_engine.sv
rtl/pyramid_sequencer.sv
rtl/gaussian_pyramid.sv
tests/pyramid_checker.sv
tests/tb_gaussian_pyramid.sv

//--- run.sh
#!/bin/sh
# compile and run the gaussian pyramid testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f all.f --top-module tb_gaussian_pyramid \
    > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_gaussian_pyramid > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation reported failure"; exit 1; }

//--- tests/tb_gaussian_pyramid.sv
`default_nettype none

`include "pyramid_config.svh"

module tb_gaussian_pyramid;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int W = `PYR_TOP_WIDTH;
    localparam int H = `PYR_TOP_HEIGHT;
    localparam int LAT = `PYR_SRC_LATENCY;
    localparam int SIZE [4] = '{W * H, W * H, W * H / 4, W * H / 4};
    localparam int RUN_LIMIT = 20 * W * H; // octave 1 blur alone needs 9 cycles a pixel

    logic                clk_in = 1'b0;
    logic                rst_in;
    logic                start_in;
    pyramid_pkg::addr_t  ext_read_addr;
    logic                ext_read_valid;
    pyramid_pkg::pixel_t ext_pixel_in = '0;
    logic                write_valid;
    pyramid_pkg::level_e level;
    pyramid_pkg::addr_t  write_addr;
    pyramid_pkg::pixel_t pixel_out;
    logic                pyramid_done;

    pyramid_pkg::pixel_t src_mem [W * H];
    pyramid_pkg::pixel_t model [4][W * H]; // expected O1L1, O1L2, O2L1, O2L2
    pyramid_pkg::addr_t  addr_hist [LAT];
    string lvl_name [4] = '{"o1l1", "o1l2", "o2l1", "o2l2"};
    int cnt [4];
    int lvl_errs [4];
    int reads;
    int done_cnt;
    int done_errs;
    int quiet_errs = 0;
    int run_num = 0;
    int tests_run = 0;
    int tests_bad = 0;
    logic running = 1'b0;
    logic active = 1'b0;
    logic idle_window = 1'b0;
    logic timed_out = 1'b0;
    logic prev_final = 1'b0;

    gaussian_pyramid UUT (.*);

    bind gaussian_pyramid pyramid_checker protocol_check (
        .clk_in(clk_in), .rst_in(rst_in), .ext_read_valid(ext_read_valid),
        .write_valid(write_valid), .level(level), .write_addr(write_addr),
        .pyramid_done(pyramid_done)
    );

    always #10 clk_in = ~clk_in;

    // source memory, pixel comes back LAT cycles after its address
    always @(posedge clk_in) begin
        #2;
        ext_pixel_in = src_mem[addr_hist[LAT - 1]];
        for (int i = LAT - 1; i > 0; i--) begin
            addr_hist[i] = addr_hist[i - 1];
        end
        addr_hist[0] = ext_read_addr;
    end

    function automatic int clamp(input int v, input int hi);
        return (v < 0) ? 0 : ((v > hi) ? hi : v);
    endfunction

    // 1 2 1 kernel both ways, edges clamped, sum >> 4
    function automatic pyramid_pkg::pixel_t blur_pixel(input int lvl, input int w, input int h,
                                                       input int x, input int y);
        int sum;
        int cx;
        int cy;
        sum = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                cx = clamp(x + dx, w - 1);
                cy = clamp(y + dy, h - 1);
                sum += int'(model[lvl][cy * w + cx]) * ((dx == 0) ? 2 : 1) * ((dy == 0) ? 2 : 1);
            end
        end
        return pyramid_pkg::pixel_t'(sum >> 4);
    endfunction

    task automatic build_model();
        for (int i = 0; i < W * H; i++) begin
            src_mem[i] = pyramid_pkg::pixel_t'($urandom);
            model[0][i] = src_mem[i];
        end
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                model[1][y * W + x] = blur_pixel(0, W, H, x, y);
            end
        end
        for (int y = 0; y < H / 2; y++) begin
            for (int x = 0; x < W / 2; x++) begin
                model[2][y * (W / 2) + x] = model[1][2 * y * W + 2 * x];
            end
        end
        for (int y = 0; y < H / 2; y++) begin
            for (int x = 0; x < W / 2; x++) begin
                model[3][y * (W / 2) + x] = blur_pixel(2, W / 2, H / 2, x, y);
            end
        end
    endtask

    task automatic check_write();
        int idx;
        int addr;
        string name;
        idx = int'(level);
        addr = int'(write_addr);
        name = $sformatf("run%0d_%s", run_num, lvl_name[idx]);
        assert (idx == 0 || cnt[idx - 1] == SIZE[idx - 1]) else begin
            $display("%s write came before the previous level was complete", name);
            lvl_errs[idx]++;
        end
        assert (idx == 3 || cnt[idx + 1] == 0) else begin
            $display("%s write came after a later level had started", name);
            lvl_errs[idx]++;
        end
        assert (addr == cnt[idx]) else begin
            $display("Error: %s address expected %0d actual %0d", name, cnt[idx], addr);
            lvl_errs[idx]++;
        end
        assert (pixel_out == model[idx][addr]) else begin
            $display("Error: %s pixel %0d expected %02h actual %02h", name, addr,
                     model[idx][addr], pixel_out);
            lvl_errs[idx]++;
        end
        cnt[idx]++;
    endtask

    // outputs sampled mid cycle
    always @(negedge clk_in) begin
        assert (!(idle_window && (write_valid || ext_read_valid || pyramid_done))) else begin
            $display("activity on the outputs after reset before any start");
            quiet_errs++;
        end
        if (running && !active) begin // a new run starts
            for (int i = 0; i < 4; i++) begin
                cnt[i] = 0;
                lvl_errs[i] = 0;
            end
            reads = 0;
            done_cnt = 0;
            done_errs = 0;
            prev_final = 1'b0;
        end
        active = running;
        if (running) begin
            if (ext_read_valid) begin
                reads++;
            end
            if (write_valid) begin
                check_write();
            end
            if (pyramid_done) begin
                done_cnt++;
                assert (prev_final) else begin
                    $display("pyramid_done came without the last O2L2 write just before it");
                    done_errs++;
                end
            end
            prev_final = write_valid && level == pyramid_pkg::O2L2
                         && int'(write_addr) == SIZE[3] - 1;
        end
    end

    task automatic report(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d error(s)", name, errs);
        end
    endtask

    task automatic run_once(input int run);
        int cycles;
        int bad;
        string tag;
        tag = $sformatf("run%0d", run);
        build_model();
        run_num = run;
        @(posedge clk_in);
        #2;
        start_in = 1'b1;
        running = 1'b1;
        @(posedge clk_in);
        #2;
        start_in = 1'b0;
        cycles = 0;
        while (cnt[1] == 0 && cycles < RUN_LIMIT) begin // wait for octave 1 blur
            @(posedge clk_in);
            cycles++;
        end
        if (cnt[1] == 0) begin
            $display("%s timed out waiting for the first O1L2 write", tag);
            timed_out = 1'b1;
            report($sformatf("%s_timeout", tag), 1);
        end else begin
            #2;
            start_in = 1'b1; // stray start in the middle of a run
            @(posedge clk_in);
            #2;
            start_in = 1'b0;
            cycles = 0;
            while (done_cnt == 0 && cycles < RUN_LIMIT) begin
                @(posedge clk_in);
                cycles++;
            end
            if (done_cnt == 0) begin
                $display("%s timed out waiting for pyramid_done", tag);
                timed_out = 1'b1;
                report($sformatf("%s_timeout", tag), 1);
            end else begin
                repeat (4) @(posedge clk_in); // room for a stray second done
                for (int i = 0; i < 4; i++) begin
                    bad = 0;
                    assert (cnt[i] == SIZE[i]) else begin
                        $display("Error: %s_%s write count expected %0d actual %0d",
                                 tag, lvl_name[i], SIZE[i], cnt[i]);
                        bad = 1;
                    end
                    report($sformatf("%s_%s", tag, lvl_name[i]), lvl_errs[i] + bad);
                end
                bad = 0;
                assert (reads == W * H) else begin
                    $display("Error: %s_reads count expected %0d actual %0d", tag, W * H, reads);
                    bad = 1;
                end
                report($sformatf("%s_reads", tag), bad);
                bad = 0;
                assert (done_cnt == 1) else begin
                    $display("Error: %s_done pulses expected 1 actual %0d", tag, done_cnt);
                    bad = 1;
                end
                report($sformatf("%s_done", tag), done_errs + bad);
            end
        end
        running = 1'b0;
    endtask

    initial begin
        void'($urandom(12107));
        rst_in = 1'b1;
        start_in = 1'b0;
        repeat (5) @(posedge clk_in);
        #2;
        rst_in = 1'b0;
        idle_window = 1'b1;
        repeat (20) @(posedge clk_in);
        idle_window = 1'b0;
        report("reset_quiet", quiet_errs);
        run_once(1);
        if (!timed_out) begin
            run_once(2); // fresh random image
        end
        $display("%0d tests, %0d failing, timeout %0d", tests_run, tests_bad, timed_out);
        if (tests_bad == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/pyramid_checker.sv
`default_nettype none

`include "pyramid_config.svh"

// protocol checks on the tagged write port of gaussian_pyramid
module pyramid_checker (
    input wire                      clk_in,
    input wire                      rst_in,
    input wire                      ext_read_valid,
    input wire                      write_valid,
    input wire pyramid_pkg::level_e level,
    input wire pyramid_pkg::addr_t  write_addr,
    input wire                      pyramid_done
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TOP_PIX = `PYR_TOP_WIDTH * `PYR_TOP_HEIGHT;

    pyramid_pkg::level_e last_level; // tag of the latest write in this run
    int                  level_size;

    always_comb begin
        if (level == pyramid_pkg::O1L1 || level == pyramid_pkg::O1L2) begin
            level_size = TOP_PIX;
        end else begin
            level_size = TOP_PIX / 4; // octave 2 is half size both ways
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || pyramid_done) begin
            last_level <= pyramid_pkg::O1L1;
        end else if (write_valid) begin
            last_level <= level;
        end
    end

    // same level again or the next one, never back and never skipping
    level_order: assert property (@(posedge clk_in) disable iff (rst_in)
        write_valid |-> (level == last_level) || ({1'b0, level} == {1'b0, last_level} + 3'd1))
        else $error("level tag went back or skipped a level");

    addr_in_level: assert property (@(posedge clk_in) disable iff (rst_in)
        write_valid |-> int'(write_addr) < level_size)
        else $error("write_addr beyond the size of its level");

    done_one_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        pyramid_done |=> !pyramid_done)
        else $error("pyramid_done held longer than one cycle");

    done_after_o2l2: assert property (@(posedge clk_in) disable iff (rst_in)
        pyramid_done |-> $past(write_valid && level == pyramid_pkg::O2L2))
        else $error("pyramid_done without an O2L2 write in the cycle before");

    reads_only_in_load: assert property (@(posedge clk_in) disable iff (rst_in)
        ext_read_valid |-> !write_valid || level == pyramid_pkg::O1L1)
        else $error("source read while a later level is being written");

endmodule

`default_nettype wire

//--- rtl/gaussian_pyramid.sv
`default_nettype none

`include "pyramid_config.svh"

// two octave, two level gaussian pyramid with one tagged write port
module gaussian_pyramid (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      start_in,
    output pyramid_pkg::addr_t       ext_read_addr,
    output logic                     ext_read_valid,
    input  wire pyramid_pkg::pixel_t ext_pixel_in,
    output logic                     write_valid,
    output pyramid_pkg::level_e      level,
    output pyramid_pkg::addr_t       write_addr,
    output pyramid_pkg::pixel_t      pixel_out,
    output logic                     pyramid_done
);

    localparam int LAT = `PYR_SRC_LATENCY;
    localparam int TOP_W = `PYR_TOP_WIDTH;
    localparam int TOP_H = `PYR_TOP_HEIGHT;

    pyramid_pkg::stage_e stage;
    logic                src_valid;
    logic                blur1_start, blur1_done;
    logic                down_start, down_done;
    logic                blur2_start, blur2_done;

    pyramid_pkg::addr_t  addr_pipe [LAT];
    logic                load_valid;
    pyramid_pkg::addr_t  load_addr;
    pyramid_pkg::pixel_t load_pixel;

    pyramid_pkg::pixel_t a_rd_data, b_rd_data, c_rd_data;
    pyramid_pkg::addr_t  blur1_rd_addr, down_rd_addr, blur2_rd_addr;
    logic                blur1_wr_valid, down_wr_valid, blur2_wr_valid;
    pyramid_pkg::addr_t  blur1_wr_addr, down_wr_addr, blur2_wr_addr;
    pyramid_pkg::pixel_t blur1_wr_data, down_wr_data, blur2_wr_data;

    pyramid_sequencer sequencer (
        .clk_in, .rst_in, .start(start_in),
        .src_addr(ext_read_addr), .src_read(ext_read_valid), .src_valid, .stage,
        .blur1_start, .blur1_done, .down_start, .down_done,
        .blur2_start, .blur2_done, .pyramid_done
    );

    // source address delayed to line up with the returning pixel
    always_ff @(posedge clk_in) begin
        addr_pipe[0] <= ext_read_addr;
        for (int i = 1; i < LAT; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
        load_addr  <= addr_pipe[LAT-1];
        load_pixel <= ext_pixel_in;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= src_valid; // written out one cycle after return
        end
    end

    level_buffer #(.DEPTH(TOP_W * TOP_H)) buf_a (
        .clk_in, .wr_en(load_valid && (stage == pyramid_pkg::LOAD)),
        .wr_addr(load_addr), .wr_data(load_pixel),
        .rd_addr(blur1_rd_addr), .rd_data(a_rd_data)
    );
    level_buffer #(.DEPTH(TOP_W * TOP_H)) buf_b (
        .clk_in, .wr_en(blur1_wr_valid && (stage == pyramid_pkg::BLUR1)),
        .wr_addr(blur1_wr_addr), .wr_data(blur1_wr_data),
        .rd_addr(down_rd_addr), .rd_data(b_rd_data)
    );
    level_buffer #(.DEPTH(TOP_W * TOP_H / 4)) buf_c (
        .clk_in, .wr_en(down_wr_valid && (stage == pyramid_pkg::DOWN)),
        .wr_addr(down_wr_addr), .wr_data(down_wr_data),
        .rd_addr(blur2_rd_addr), .rd_data(c_rd_data)
    );

    blur_engine #(.WIDTH(TOP_W), .HEIGHT(TOP_H)) blur_o1 (
        .clk_in, .rst_in, .start(blur1_start),
        .rd_addr(blur1_rd_addr), .rd_data(a_rd_data),
        .wr_valid(blur1_wr_valid), .wr_addr(blur1_wr_addr), .wr_data(blur1_wr_data),
        .done(blur1_done)
    );
    downsample_engine #(.OLD_WIDTH(TOP_W), .OLD_HEIGHT(TOP_H)) downsampler (
        .clk_in, .rst_in, .start(down_start),
        .rd_addr(down_rd_addr), .rd_data(b_rd_data),
        .wr_valid(down_wr_valid), .wr_addr(down_wr_addr), .wr_data(down_wr_data),
        .done(down_done)
    );
    blur_engine #(.WIDTH(TOP_W / 2), .HEIGHT(TOP_H / 2)) blur_o2 (
        .clk_in, .rst_in, .start(blur2_start),
        .rd_addr(blur2_rd_addr), .rd_data(c_rd_data),
        .wr_valid(blur2_wr_valid), .wr_addr(blur2_wr_addr), .wr_data(blur2_wr_data),
        .done(blur2_done)
    );

    // one write stream per stage reaches the output port
    always_comb begin
        write_valid = 1'b0;
        level       = pyramid_pkg::O1L1;
        write_addr  = '0;
        pixel_out   = '0;
        case (stage)
            pyramid_pkg::LOAD: begin
                write_valid = load_valid;
                write_addr  = load_addr;
                pixel_out   = load_pixel;
            end
            pyramid_pkg::BLUR1: begin
                write_valid = blur1_wr_valid;
                level       = pyramid_pkg::O1L2;
                write_addr  = blur1_wr_addr;
                pixel_out   = blur1_wr_data;
            end
            pyramid_pkg::DOWN: begin
                write_valid = down_wr_valid;
                level       = pyramid_pkg::O2L1;
                write_addr  = down_wr_addr;
                pixel_out   = down_wr_data;
            end
            pyramid_pkg::BLUR2: begin
                write_valid = blur2_wr_valid; // O2L2 leaves only through here
                level       = pyramid_pkg::O2L2;
                write_addr  = blur2_wr_addr;
                pixel_out   = blur2_wr_data;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/pyramid_sequencer.sv
`default_nettype none

`include "pyramid_config.svh"

// stage FSM: load source, blur octave 1, downsample, blur octave 2
module pyramid_sequencer (
    input  wire                 clk_in,
    input  wire                 rst_in,
    input  wire                 start,
    output pyramid_pkg::addr_t  src_addr,
    output logic                src_read,
    output logic                src_valid,
    output pyramid_pkg::stage_e stage,
    output logic                blur1_start,
    input  wire                 blur1_done,
    output logic                down_start,
    input  wire                 down_done,
    output logic                blur2_start,
    input  wire                 blur2_done,
    output logic                pyramid_done
);

    localparam int LAT = `PYR_SRC_LATENCY;
    localparam int NUM_PIX = `PYR_TOP_WIDTH * `PYR_TOP_HEIGHT;

    logic [LAT-1:0] read_pipe;
    logic [LAT:0]   last_pipe; // one stage longer, covers the load write
    logic           read_last;

    assign read_last = src_read && (src_addr == pyramid_pkg::addr_t'(NUM_PIX - 1));
    assign src_valid = read_pipe[LAT-1]; // pixel is on ext_pixel_in now

    // end of BLUR2 closes the run
    assign pyramid_done = (stage == pyramid_pkg::BLUR2) && blur2_done;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stage       <= pyramid_pkg::IDLE;
            src_addr    <= '0;
            src_read    <= 1'b0;
            read_pipe   <= '0;
            last_pipe   <= '0;
            blur1_start <= 1'b0;
            down_start  <= 1'b0;
            blur2_start <= 1'b0;
        end else begin
            read_pipe   <= LAT'({read_pipe, src_read});
            last_pipe   <= (LAT + 1)'({last_pipe, read_last});
            blur1_start <= 1'b0;
            down_start  <= 1'b0;
            blur2_start <= 1'b0;
            case (stage)
                pyramid_pkg::IDLE: begin
                    if (start) begin
                        stage    <= pyramid_pkg::LOAD;
                        src_addr <= '0;
                        src_read <= 1'b1;
                    end
                end
                pyramid_pkg::LOAD: begin
                    if (src_read) begin
                        if (read_last) begin
                            src_read <= 1'b0;
                        end else begin
                            src_addr <= src_addr + 1'b1;
                        end
                    end
                    // last source pixel has been written out
                    if (last_pipe[LAT]) begin
                        stage       <= pyramid_pkg::BLUR1;
                        blur1_start <= 1'b1;
                    end
                end
                pyramid_pkg::BLUR1: begin
                    if (blur1_done) begin
                        stage      <= pyramid_pkg::DOWN;
                        down_start <= 1'b1;
                    end
                end
                pyramid_pkg::DOWN: begin
                    if (down_done) begin
                        stage       <= pyramid_pkg::BLUR2;
                        blur2_start <= 1'b1;
                    end
                end
                pyramid_pkg::BLUR2: begin
                    if (blur2_done) begin
                        stage <= pyramid_pkg::IDLE;
                    end
                end
                default: stage <= pyramid_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/downsample_engine.sv
`default_nettype none

// keeps pixel (2x, 2y) of the old image as pixel (x, y) of the new one
module downsample_engine #(
    parameter int OLD_WIDTH = 16,
    parameter int OLD_HEIGHT = 16
) (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      start,
    output pyramid_pkg::addr_t       rd_addr,
    input  wire pyramid_pkg::pixel_t rd_data,
    output logic                     wr_valid,
    output pyramid_pkg::addr_t       wr_addr,
    output pyramid_pkg::pixel_t      wr_data,
    output logic                     done
);

    localparam int NEW_W = OLD_WIDTH / 2;
    localparam int NEW_H = OLD_HEIGHT / 2;
    localparam int XW = $clog2(NEW_W);
    localparam int YW = $clog2(NEW_H);

    logic               busy;
    logic [XW-1:0]      hx;
    logic [YW-1:0]      hy;
    logic               rd_pend;
    pyramid_pkg::addr_t cur_addr;
    pyramid_pkg::addr_t pend_addr;

    assign rd_addr  = pyramid_pkg::addr_t'(2 * hy * OLD_WIDTH + 2 * hx);
    assign cur_addr = pyramid_pkg::addr_t'(hy * NEW_W + hx); // half size raster address

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy     <= 1'b0;
            hx       <= '0;
            hy       <= '0;
            rd_pend  <= 1'b0;
            wr_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            rd_pend  <= busy;
            wr_valid <= rd_pend;
            done     <= wr_valid && (wr_addr == pyramid_pkg::addr_t'(NEW_W * NEW_H - 1));
            if (start && !busy) begin
                busy <= 1'b1;
                hx   <= '0;
                hy   <= '0;
            end else if (busy) begin
                if (hx != XW'(NEW_W - 1)) begin
                    hx <= hx + 1'b1;
                end else begin
                    hx <= '0;
                    if (hy != YW'(NEW_H - 1)) begin
                        hy <= hy + 1'b1;
                    end else begin
                        hy   <= '0;
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // address rides along with the read, two cycles to the write
    always_ff @(posedge clk_in) begin
        pend_addr <= cur_addr;
        wr_addr   <= pend_addr;
        wr_data   <= rd_data;
    end

endmodule

`default_nettype wire

//--- rtl/blur_engine.sv
`default_nettype none

// 3x3 gaussian (1 2 1 / 2 4 2 / 1 2 1) over an image held in a level buffer
// nine reads per output pixel, edges clamped
module blur_engine #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 16
) (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      start,
    output pyramid_pkg::addr_t       rd_addr,
    input  wire pyramid_pkg::pixel_t rd_data,
    output logic                     wr_valid,
    output pyramid_pkg::addr_t       wr_addr,
    output pyramid_pkg::pixel_t      wr_data,
    output logic                     done
);

    localparam int XW = $clog2(WIDTH);
    localparam int YW = $clog2(HEIGHT);
    localparam int ACC_W = $bits(pyramid_pkg::pixel_t) + 4; // kernel sums to 16
    localparam int NUM_PIX = WIDTH * HEIGHT;

    logic             busy;
    logic [XW-1:0]    x;
    logic [YW-1:0]    y;
    logic [XW-1:0]    sx;
    logic [YW-1:0]    sy;
    logic [1:0]       tap_col;
    logic [1:0]       tap_row;
    logic [1:0]       shift;
    logic [1:0]       shift_q;
    logic             rd_pend;
    logic             first_q;
    logic             last_q;
    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] weighted;
    logic [ACC_W-1:0] sum;
    pyramid_pkg::addr_t out_addr;

    // tap coordinate, clamped to the image
    always_comb begin
        case (tap_col)
            2'd0:    sx = (x == '0) ? x : x - 1'b1;
            2'd2:    sx = (x == XW'(WIDTH - 1)) ? x : x + 1'b1;
            default: sx = x;
        endcase
        case (tap_row)
            2'd0:    sy = (y == '0) ? y : y - 1'b1;
            2'd2:    sy = (y == YW'(HEIGHT - 1)) ? y : y + 1'b1;
            default: sy = y;
        endcase
        rd_addr = pyramid_pkg::addr_t'(sy * WIDTH + sx);
        // weight 1, 2 or 4 as a left shift
        shift = ((tap_col == 2'd1) ? 2'd1 : 2'd0) + ((tap_row == 2'd1) ? 2'd1 : 2'd0);
    end

    assign weighted = ACC_W'(rd_data) << shift_q;
    assign sum = first_q ? weighted : acc + weighted; // tap 0 restarts the sum

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy     <= 1'b0;
            x        <= '0;
            y        <= '0;
            tap_col  <= '0;
            tap_row  <= '0;
            rd_pend  <= 1'b0;
            wr_valid <= 1'b0;
            done     <= 1'b0;
            out_addr <= '0;
        end else begin
            rd_pend  <= busy;
            wr_valid <= rd_pend && last_q;
            done     <= wr_valid && (wr_addr == pyramid_pkg::addr_t'(NUM_PIX - 1));
            if (start && !busy) begin
                busy     <= 1'b1;
                x        <= '0;
                y        <= '0;
                tap_col  <= '0;
                tap_row  <= '0;
                out_addr <= '0;
            end else if (busy) begin
                if (tap_col != 2'd2) begin
                    tap_col <= tap_col + 1'b1;
                end else begin
                    tap_col <= '0;
                    if (tap_row != 2'd2) begin
                        tap_row <= tap_row + 1'b1;
                    end else begin
                        tap_row <= '0;
                        if (x != XW'(WIDTH - 1)) begin
                            x <= x + 1'b1;
                        end else begin
                            x <= '0;
                            if (y != YW'(HEIGHT - 1)) begin
                                y <= y + 1'b1;
                            end else begin
                                y    <= '0;
                                busy <= 1'b0; // last read issued
                            end
                        end
                    end
                end
            end
            if (rd_pend && last_q) begin
                out_addr <= out_addr + 1'b1; // writes come out in raster order
            end
        end
    end

    // tap info follows its read by one cycle, like the buffer data
    always_ff @(posedge clk_in) begin
        shift_q <= shift;
        first_q <= (tap_col == 2'd0) && (tap_row == 2'd0);
        last_q  <= (tap_col == 2'd2) && (tap_row == 2'd2);
        if (rd_pend) begin
            acc <= sum;
        end
        if (rd_pend && last_q) begin
            wr_addr <= out_addr;
            wr_data <= pyramid_pkg::pixel_t'(sum >> 4);
        end
    end

endmodule

`default_nettype wire

//--- rtl/level_buffer.sv
`default_nettype none

// one pyramid level, simple dual port with a registered read
module level_buffer #(
    parameter int DEPTH = 256
) (
    input  wire                      clk_in,
    input  wire                      wr_en,
    input  wire pyramid_pkg::addr_t  wr_addr,
    input  wire pyramid_pkg::pixel_t wr_data,
    input  wire pyramid_pkg::addr_t  rd_addr,
    output pyramid_pkg::pixel_t      rd_data
);

    localparam int AW = $clog2(DEPTH);

    pyramid_pkg::pixel_t mem [DEPTH];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr[AW-1:0]] <= wr_data;
        end
        rd_data <= mem[rd_addr[AW-1:0]]; // data lags address by one cycle
    end

endmodule

`default_nettype wire

//--- rtl/pyramid_pkg.sv
`default_nettype none

`include "pyramid_config.svh"

package pyramid_pkg;

    typedef logic [`PYR_BIT_DEPTH-1:0] pixel_t;

    // one raster address width for every level, sized by the top image
    localparam int ADDR_W = $clog2(`PYR_TOP_WIDTH * `PYR_TOP_HEIGHT);
    typedef logic [ADDR_W-1:0] addr_t;

    // tag on the shared write port
    typedef enum logic [1:0] {O1L1, O1L2, O2L1, O2L2} level_e;

    typedef enum logic [2:0] {IDLE, LOAD, BLUR1, DOWN, BLUR2} stage_e;

endpackage

`default_nettype wire

//--- include/pyramid_config.svh
`ifndef PYRAMID_CONFIG_SVH
`define PYRAMID_CONFIG_SVH

// greyscale pixel depth in bits
`define PYR_BIT_DEPTH 8

// source image size, both dimensions even so octave 2 halves cleanly
`define PYR_TOP_WIDTH 16
`define PYR_TOP_HEIGHT 16

// cycles from ext_read_addr to ext_pixel_in
`define PYR_SRC_LATENCY 2

`endif
